/* logic/risc8_pkg.sv */
// risc8 shared definitions
// datapath widths, instruction classes, alu op codes and status flag bits
package risc8_pkg;

	// opcode word and datapath widths
	localparam int OPCODE_W = 16;
	localparam int DATA_W = 8;
	localparam int REG_SEL_W = 5;

	// out writes land in data space just above the register file
	localparam logic [7:0] IO_OFFSET = 8'h20;

	// instruction groups as seen by the sequencer
	typedef enum logic [2:0] {
		CLS_NOP,
		CLS_ALU,
		CLS_ALU_IMM,
		CLS_RJMP,
		CLS_BRANCH,
		CLS_OUT
	} instr_class_t;

	// second stage operations
	// subtract also covers the compares, move covers LDI and MOV
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOVE
	} alu_op_t;

	// status register bit positions, bits 4-7 always read zero
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;

endpackage

/* logic/risc8_decode.sv */
`timescale 1ns/100ps
// risc8 instruction decoder
// classifies the stage-1 opcode and extracts the register, constant,
// i/o and branch fields for the sequencer and the execute stage
module risc8_decode import risc8_pkg::*; (
	input logic [OPCODE_W-1:0] opcode,
	output instr_class_t cls,
	output alu_op_t alu_op,
	output logic use_carry,
	output logic store,
	output logic use_const,
	output logic [DATA_W-1:0] const_value,
	output logic [REG_SEL_W-1:0] sel_a,
	output logic [REG_SEL_W-1:0] sel_b,
	output logic [REG_SEL_W-1:0] sel_d,
	output logic [5:0] io_addr,
	output logic [2:0] branch_bit,
	output logic branch_if_set,
	output logic [11:0] offset
);
	// Rd of the full register forms, and r16-r31 of the immediate forms
	logic [REG_SEL_W-1:0] op_rd;
	logic [REG_SEL_W-1:0] op_rdi;

	assign op_rd = opcode[8:4];
	assign op_rdi = {1'b1, opcode[7:4]};

	// Rr is split around the Rd field
	assign sel_b = {opcode[9], opcode[3:0]};
	// K is split the same way in the immediate forms
	assign const_value = {opcode[11:8], opcode[3:0]};
	assign io_addr = {opcode[10:9], opcode[3:0]};
	assign branch_bit = opcode[2:0];
	// BRBS has bit 10 clear, BRBC has it set
	assign branch_if_set = !opcode[10];
	// rjmp uses all 12 bits, branch k is 7 bits widened to 12
	assign offset = (cls == CLS_BRANCH) ? {{5{opcode[9]}}, opcode[9:3]} : opcode[11:0];

	always_comb begin
		// anything unmatched runs as a no-op move without store
		cls = CLS_NOP;
		alu_op = ALU_MOVE;
		use_carry = 1'b0;
		store = 1'b0;
		use_const = 1'b0;
		sel_a = op_rd;
		sel_d = op_rd;

		casez (opcode[15:10])
		// ADD, ADC
		6'b000?11: begin
			cls = CLS_ALU;
			alu_op = ALU_ADD;
			use_carry = opcode[12];
			store = 1'b1;
		end
		// SBC, SUB, and CP which compares without a store
		6'b000?10, 6'b000101: begin
			cls = CLS_ALU;
			alu_op = ALU_SUB;
			use_carry = !opcode[12];
			store = opcode[11];
		end
		// AND, EOR, OR, MOV
		6'b0010??: begin
			cls = CLS_ALU;
			store = 1'b1;
			case (opcode[11:10])
			2'b00: alu_op = ALU_AND;
			2'b01: alu_op = ALU_EOR;
			2'b10: alu_op = ALU_OR;
			default: alu_op = ALU_MOVE;
			endcase
		end
		// CPI, SBCI, SUBI
		6'b0011??, 6'b010???: begin
			cls = CLS_ALU_IMM;
			alu_op = ALU_SUB;
			use_carry = (opcode[15:12] == 4'b0100);
			store = opcode[14];
		end
		// ORI, ANDI
		6'b011???: begin
			cls = CLS_ALU_IMM;
			alu_op = opcode[12] ? ALU_AND : ALU_OR;
			store = 1'b1;
		end
		// LDI is a move of the constant
		6'b1110??: begin
			cls = CLS_ALU_IMM;
			store = 1'b1;
		end
		6'b1100??: cls = CLS_RJMP;
		6'b11110?: cls = CLS_BRANCH;
		6'b10111?: cls = CLS_OUT;
		default: cls = CLS_NOP;
		endcase

		// immediate forms work on r16-r31 with K as the second operand
		if (cls == CLS_ALU_IMM) begin
			use_const = 1'b1;
			sel_a = op_rdi;
			sel_d = op_rdi;
		end
	end

endmodule

/* logic/risc8_sequencer.sv */
`timescale 1ns/100ps
// risc8 sequencer
// owns the pc and the out cycle, picks the stage-1 opcode,
// resolves rjmp and branches and drives the data bus strobes
module risc8_sequencer import risc8_pkg::*; #(
	parameter int PC_WIDTH = 16
) (
	input logic clk,
	input logic reset,
	input instr_class_t cls,
	input logic [11:0] offset,
	input logic [2:0] branch_bit,
	input logic branch_if_set,
	input logic [DATA_W-1:0] next_sreg,
	input logic [5:0] io_addr,
	input logic [DATA_W-1:0] reg_a,
	input logic [OPCODE_W-1:0] cdata,
	output logic [OPCODE_W-1:0] opcode,
	output logic [PC_WIDTH-1:0] pc,
	output logic [16-1:0] data_addr,
	output logic data_wen,
	output logic [DATA_W-1:0] data_write
);
	// address of the opcode now on cdata
	logic [PC_WIDTH-1:0] pc_q;
	logic [PC_WIDTH-1:0] pc_inc;
	logic [PC_WIDTH-1:0] offset_ext;
	// high during the second cycle of out
	logic out_cycle;
	logic out_first;
	logic [OPCODE_W-1:0] prev_opcode;
	logic take_jump;

	// the second out cycle replays the latched opcode, cdata is a refetch
	assign opcode = out_cycle ? prev_opcode : cdata;
	assign out_first = (cls == CLS_OUT) && !out_cycle;

	assign pc_inc = pc_q + PC_WIDTH'(1);
	assign offset_ext = PC_WIDTH'($signed(offset));

	// branch looks at the flags the previous instruction is producing now
	assign take_jump = (cls == CLS_RJMP)
		|| ((cls == CLS_BRANCH) && (next_sreg[branch_bit] == branch_if_set));

	// pc goes straight to program memory, so a jump costs no bubble
	always_comb begin
		if (reset)
			pc = '0;
		else if (take_jump)
			pc = pc_inc + offset_ext;
		else
			pc = pc_inc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= '0;
			out_cycle <= 1'b0;
		end else begin
			out_cycle <= out_first;
			// pc register holds while out waits on its register read
			if (!out_first)
				pc_q <= pc;
		end
	end

	always_ff @(posedge clk)
		prev_opcode <= opcode;

	// Rr arrives on reg_a in the second cycle
	assign data_wen = out_cycle;
	assign data_addr = 16'(io_addr) + 16'(IO_OFFSET);
	assign data_write = reg_a;

	// a bus write always belongs to the out being replayed
	assert property (@(posedge clk) disable iff (reset) data_wen |-> (cls == CLS_OUT));

endmodule

/* logic/risc8_regs.sv */
`timescale 1ns/100ps
// risc8 register file
// 32 x 8 flops with two registered read ports and one write port,
// a read of the register being written returns the new value
module risc8_regs import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [REG_SEL_W-1:0] sel_a,
	input logic [REG_SEL_W-1:0] sel_b,
	output logic [DATA_W-1:0] reg_a,
	output logic [DATA_W-1:0] reg_b,
	input logic [REG_SEL_W-1:0] wb_sel,
	input logic [DATA_W-1:0] wb_data,
	input logic wb_store
);
	logic [DATA_W-1:0] regs [2**REG_SEL_W];
	logic write_en;

	// nothing gets written while the core is held in reset
	assign write_en = wb_store && !reset;

	always_ff @(posedge clk) begin
		if (write_en)
			regs[wb_sel] <= wb_data;

		// bypass the writeback so back to back ops see fresh data
		if (write_en && (wb_sel == sel_a))
			reg_a <= wb_data;
		else
			reg_a <= regs[sel_a];

		if (write_en && (wb_sel == sel_b))
			reg_b <= wb_data;
		else
			reg_b <= regs[sel_b];
	end

endmodule

/* logic/risc8_execute.sv */
`timescale 1ns/100ps
// risc8 execute stage
// latches the stage-1 controls, runs the alu on the register reads
// and drives writeback, keeps C/Z/N/V in the status register
module risc8_execute import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	input alu_op_t alu_op,
	input logic use_carry,
	input logic store,
	input logic use_const,
	input logic [DATA_W-1:0] const_value,
	input logic [REG_SEL_W-1:0] sel_d,
	input logic [DATA_W-1:0] reg_a,
	input logic [DATA_W-1:0] reg_b,
	output logic [REG_SEL_W-1:0] wb_sel,
	output logic [DATA_W-1:0] wb_data,
	output logic wb_store,
	output logic [DATA_W-1:0] next_sreg
);
	alu_op_t op_q;
	logic carry_q;
	logic use_const_q;
	logic [DATA_W-1:0] const_q;
	logic [DATA_W-1:0] sreg;
	logic [DATA_W-1:0] opnd_b;
	logic [DATA_W:0] cin_ext;
	logic [DATA_W:0] sum;
	logic [DATA_W-1:0] result;
	logic res_zero;

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= ALU_MOVE;
			carry_q <= 1'b0;
			use_const_q <= 1'b0;
			wb_store <= 1'b0;
			sreg <= '0;
		end else begin
			op_q <= alu_op;
			carry_q <= use_carry;
			use_const_q <= use_const;
			wb_store <= store;
			sreg <= next_sreg;
		end
	end

	always_ff @(posedge clk) begin
		const_q <= const_value;
		wb_sel <= sel_d;
	end

	// immediate forms replace Rr with K
	assign opnd_b = use_const_q ? const_q : reg_b;
	assign cin_ext = {{DATA_W{1'b0}}, carry_q & sreg[FLAG_C]};
	assign res_zero = (result == '0);
	assign wb_data = result;

	always_comb begin
		// upper status bits stay zero, flags carry over by default
		next_sreg = '0;
		next_sreg[FLAG_C] = sreg[FLAG_C];
		next_sreg[FLAG_Z] = sreg[FLAG_Z];
		next_sreg[FLAG_N] = sreg[FLAG_N];
		next_sreg[FLAG_V] = sreg[FLAG_V];
		sum = '0;
		result = opnd_b;

		case (op_q)
		ALU_ADD: begin
			sum = {1'b0, reg_a} + {1'b0, opnd_b} + cin_ext;
			result = sum[DATA_W-1:0];
			next_sreg[FLAG_C] = sum[DATA_W];
			// operands alike in sign, result not
			next_sreg[FLAG_V] = (reg_a[DATA_W-1] == opnd_b[DATA_W-1])
				&& (result[DATA_W-1] != reg_a[DATA_W-1]);
		end
		ALU_SUB: begin
			// top bit of the wide difference is the borrow
			sum = {1'b0, reg_a} - {1'b0, opnd_b} - cin_ext;
			result = sum[DATA_W-1:0];
			next_sreg[FLAG_C] = sum[DATA_W];
			next_sreg[FLAG_V] = (reg_a[DATA_W-1] != opnd_b[DATA_W-1])
				&& (result[DATA_W-1] != reg_a[DATA_W-1]);
		end
		ALU_AND: begin
			result = reg_a & opnd_b;
			next_sreg[FLAG_V] = 1'b0;
		end
		ALU_OR: begin
			result = reg_a | opnd_b;
			next_sreg[FLAG_V] = 1'b0;
		end
		ALU_EOR: begin
			result = reg_a ^ opnd_b;
			next_sreg[FLAG_V] = 1'b0;
		end
		default: result = opnd_b;
		endcase

		// move leaves Z and N alone, like the other flags
		if (op_q != ALU_MOVE) begin
			next_sreg[FLAG_N] = result[DATA_W-1];
			// sbc/sbci chain Z across bytes of a multi-byte compare
			if ((op_q == ALU_SUB) && carry_q)
				next_sreg[FLAG_Z] = res_zero && sreg[FLAG_Z];
			else
				next_sreg[FLAG_Z] = res_zero;
		end
	end

	// carry in only makes sense for the add and subtract forms
	assert property (@(posedge clk) disable iff (reset)
		use_carry |-> ((alu_op == ALU_ADD) || (alu_op == ALU_SUB)));

endmodule

/* logic/risc8_core.sv */
`timescale 1ns/100ps
// risc8 core top level
// two stage AVR-style 8-bit pipeline, one opcode word per cycle
// in from program memory and an out-only data bus
module risc8_core import risc8_pkg::*; #(
	parameter int PC_WIDTH = 16
) (
	input logic clk,
	input logic reset,
	output logic [PC_WIDTH-1:0] pc,
	input logic [OPCODE_W-1:0] cdata,
	output logic [15:0] data_addr,
	output logic data_wen,
	output logic [DATA_W-1:0] data_write
);
	// stage 1 decode results
	logic [OPCODE_W-1:0] opcode;
	instr_class_t cls;
	alu_op_t alu_op;
	logic use_carry;
	logic store;
	logic use_const;
	logic [DATA_W-1:0] const_value;
	logic [REG_SEL_W-1:0] sel_a;
	logic [REG_SEL_W-1:0] sel_b;
	logic [REG_SEL_W-1:0] sel_d;
	logic [5:0] io_addr;
	logic [2:0] branch_bit;
	logic branch_if_set;
	logic [11:0] offset;

	// register reads and stage 2 writeback
	logic [DATA_W-1:0] reg_a;
	logic [DATA_W-1:0] reg_b;
	logic [REG_SEL_W-1:0] wb_sel;
	logic [DATA_W-1:0] wb_data;
	logic wb_store;
	logic [DATA_W-1:0] next_sreg;

	risc8_decode u_decode (
		.opcode,
		.cls, .alu_op, .use_carry, .store, .use_const, .const_value,
		.sel_a, .sel_b, .sel_d,
		.io_addr, .branch_bit, .branch_if_set, .offset
	);

	risc8_sequencer #(
		.PC_WIDTH(PC_WIDTH)
	) u_sequencer (
		.clk, .reset,
		.cls, .offset, .branch_bit, .branch_if_set, .next_sreg,
		.io_addr, .reg_a, .cdata, .opcode, .pc,
		.data_addr, .data_wen, .data_write
	);

	risc8_regs u_regs (
		.clk, .reset,
		.sel_a, .sel_b, .reg_a, .reg_b,
		.wb_sel, .wb_data, .wb_store
	);

	// next_sreg feeds back into stage 1 for the branch test
	risc8_execute u_execute (
		.clk, .reset,
		.alu_op, .use_carry, .store, .use_const, .const_value, .sel_d,
		.reg_a, .reg_b,
		.wb_sel, .wb_data, .wb_store, .next_sreg
	);

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/100ps
// testbench clock and reset generator
// free running clock, reset held for a fixed number of cycles at start
// and again each time reset_req rises
module tb_clock #(
	parameter int HALF_PERIOD = 50,
	parameter int RESET_CYCLES = 5
) (
	input logic reset_req,
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset edges land just after the rising clock edge
	initial begin
		reset = 1'b1;
		forever begin
			repeat (RESET_CYCLES) @(posedge clk);
			#1 reset = 1'b0;
			@(posedge reset_req);
			#1 reset = 1'b1;
		end
	end

endmodule

/* verification/risc8_tb.sv */
`timescale 1ns/100ps
// risc8 core testbench
// runs a table of short programs from a program memory model and checks
// every data bus write against the expected address and byte, in order
module risc8_tb;
	localparam int PC_WIDTH = 8;
	localparam int NUM_PROGS = 4;
	localparam int PROG_LEN = 20;
	localparam int MAX_WRITES = 4;
	localparam int TAIL_CYCLES = 3;
	// rjmp -1, every program parks here
	localparam logic [15:0] LOOP_WORD = 16'hCFFF;

	// 0: LDI, SUBI, ANDI, ORI then OUT, covers bus address 0x20 and 0x5F
	// 1: ADD/ADC and SUB/SBC across a byte boundary, back to back
	// 2: forward RJMP over an OUT, then a backward RJMP onto one
	// 3: CPI and CP right before BREQ, BRCC, BRNE, BRCS
	localparam logic [15:0] PROGRAMS [NUM_PROGS][PROG_LEN] = '{
		'{16'hE50A, 16'hB900, 16'h510B, 16'hB901, 16'hEC13, 16'h751E, 16'h6910,
			16'hBF1F, 16'hCFFF, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'hEF00, 16'hE011, 16'hE030, 16'hE320, 16'h0F02, 16'h1F13, 16'hB902,
			16'hB913, 16'hE040, 16'hE052, 16'hE070, 16'hE061, 16'h1B46, 16'h0B57,
			16'hB944, 16'hB955, 16'hCFFF, 16'h0000, 16'h0000, 16'h0000},
		'{16'hE101, 16'hC001, 16'hB906, 16'hE202, 16'hB907, 16'hC002, 16'hB908,
			16'hCFFF, 16'hE303, 16'hCFFC, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
		'{16'hE400, 16'h3400, 16'hF009, 16'hB909, 16'h3401, 16'hF408, 16'hB90A,
			16'hE410, 16'h1701, 16'hF409, 16'hB91B, 16'h3510, 16'hF008, 16'hB91C,
			16'hBF0F, 16'hCFFF, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
	};
	localparam int PROG_LENGTH [NUM_PROGS] = '{9, 17, 10, 16};
	localparam int EXP_COUNT [NUM_PROGS] = '{3, 4, 2, 3};
	// 5A-1B = 3F, (C3 & 5E) | 90 = D2, 01F0+0030 = 0220, 0200-0001 = 01FF
	localparam logic [15:0] EXP_ADDR [NUM_PROGS][MAX_WRITES] = '{
		'{16'h0020, 16'h0021, 16'h005F, 16'h0000},
		'{16'h0022, 16'h0023, 16'h0024, 16'h0025},
		'{16'h0027, 16'h0028, 16'h0000, 16'h0000},
		'{16'h002A, 16'h002B, 16'h005F, 16'h0000}
	};
	localparam logic [7:0] EXP_DATA [NUM_PROGS][MAX_WRITES] = '{
		'{8'h5A, 8'h3F, 8'hD2, 8'h00},
		'{8'h20, 8'h02, 8'hFF, 8'h01},
		'{8'h22, 8'h33, 8'h00, 8'h00},
		'{8'h40, 8'h40, 8'h40, 8'h00}
	};

	logic clk;
	logic reset;
	logic reset_req;
	logic [PC_WIDTH-1:0] pc;
	logic [15:0] cdata;
	logic [15:0] data_addr;
	logic data_wen;
	logic [7:0] data_write;
	logic [15:0] rom [2**PC_WIDTH];
	logic [15:0] fetch_word;
	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	int timeout_cycles = 0;

	tb_clock clock_gen (
		.reset_req,
		.clk,
		.reset
	);

	risc8_core #(
		.PC_WIDTH(PC_WIDTH)
	) DUT (
		.clk, .reset, .pc, .cdata,
		.data_addr, .data_wen, .data_write
	);

	// program memory answers one cycle after the address
	always @(posedge clk) begin
		fetch_word = rom[pc];
		#1 cdata = fetch_word;
	end

	// watchdog, limit is set from the program lengths before the first edge
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == timeout_cycles) begin
			$display("timeout after %0d cycles, a program never reached its end loop",
				cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	task automatic run_program(input int p);
		int seen;
		int tail;
		bit done;
		seen = 0;
		tail = 0;
		done = 1'b0;
		// first program starts under the power-on reset
		if (p > 0) begin
			@(posedge clk);
			#1 reset_req = 1'b1;
			wait (reset);
			reset_req = 1'b0;
		end
		for (int a = 0; a < 2**PC_WIDTH; a++)
			rom[a] = 16'h0000;
		for (int a = 0; a < PROG_LEN; a++)
			rom[a] = PROGRAMS[p][a];

		// sample mid-cycle, away from both edges
		@(negedge clk);
		while (reset) begin
			check_value("pc", 16'(pc), 16'h0000);
			check_value("data_wen", 16'(data_wen), 16'h0000);
			@(negedge clk);
		end
		// first cycle out of reset has no write
		check_value("data_wen", 16'(data_wen), 16'h0000);

		while (tail < TAIL_CYCLES) begin
			if (data_wen) begin
				if (seen < EXP_COUNT[p]) begin
					check_value("data_addr", data_addr, EXP_ADDR[p][seen]);
					check_value("data_write", 16'(data_write), 16'(EXP_DATA[p][seen]));
				end else begin
					errors++;
					$display("program %0d wrote %h to %h, no more writes were expected",
						p, data_write, data_addr);
				end
				seen++;
			end
			// a few extra cycles on the end loop catch late writes
			if (cdata == LOOP_WORD)
				done = 1'b1;
			if (done)
				tail++;
			@(negedge clk);
		end

		if (seen < EXP_COUNT[p]) begin
			errors++;
			$display("program %0d made only %0d of its %0d expected bus writes",
				p, seen, EXP_COUNT[p]);
		end
	endtask

	initial begin
		int total;
		total = 0;
		reset_req = 1'b0;
		cdata = 16'h0000;
		for (int p = 0; p < NUM_PROGS; p++)
			total += PROG_LENGTH[p];
		timeout_cycles = total * 2 + 50;

		for (int p = 0; p < NUM_PROGS; p++)
			run_program(p);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* src.f */
logic/risc8_pkg.sv
logic/risc8_decode.sv
logic/risc8_sequencer.sv
logic/risc8_regs.sv
logic/risc8_execute.sv
logic/risc8_core.sv
verification/tb_clock.sv
verification/risc8_tb.sv

/* Makefile */
# Verilator build and run of the risc8 testbench

VERILATOR ?= verilator
TOP ?= risc8_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
